// File: rtl/uart_pkg.sv
package uart_pkg;

    localparam int DATA_W    = 32;  // host data bus width
    localparam int CNT_W_DEF = 16;  // default baud counter width

    // host word addresses
    typedef enum logic [1:0]
    {
        CTRL_A = 2'd0,
        COMP_A = 2'd1,
        TXD_A  = 2'd2,
        STAT_A = 2'd3
    } uart_addr_e;

    // control register, tr_en sits in bit 0
    typedef struct packed
    {
        logic rec_en;   // receiver enable
        logic tr_en;    // transmitter enable
    } uart_ctrl_t;

    // status byte as returned in rdata[7:0]
    typedef struct packed
    {
        logic [4:0] rsvd;           // always zero
        logic       rx_frame_err;   // stop bit was low
        logic       rx_valid;       // unread byte held
        logic       tx_busy;        // request pending or frame in flight
    } uart_stat_t;

endpackage : uart_pkg

// File: rtl/uart_reg_decode.sv
`timescale 1ns/1ps

module uart_reg_decode
    import uart_pkg::*;
#(
    parameter int CNT_W = CNT_W_DEF
)
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                we,         // host write strobe
    input  uart_addr_e          addr,       // word address
    input  logic [DATA_W-1:0]   wdata,      // host write data
    input  logic                req_ack,    // end of frame from transmitter
    output uart_ctrl_t          ctrl,       // enables
    output logic [CNT_W-1:0]    comp,       // bit length minus one
    output logic [7:0]          tx_data,    // byte to send
    output logic                req         // transmit request level
);

    logic wr_ctrl;
    logic wr_comp;
    logic wr_txd;
    logic tx_accept;

    assign wr_ctrl = we && (addr == CTRL_A);
    assign wr_comp = we && (addr == COMP_A);
    assign wr_txd  = we && (addr == TXD_A);

    // a byte is taken only when nothing is pending and the transmitter is on
    assign tx_accept = wr_txd && !req && ctrl.tr_en;

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            ctrl <= '0;
            comp <= '0;
        end
        else
        begin
            if (wr_ctrl)
            begin
                ctrl <= uart_ctrl_t'(wdata[$bits(uart_ctrl_t)-1:0]);
            end
            if (wr_comp)
            begin
                comp <= CNT_W'(wdata);
            end
        end
    end

    // request level, dropped by the acknowledge or a disabled transmitter
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            req <= 1'b0;
        end
        else if (!ctrl.tr_en)
        begin
            req <= 1'b0;
        end
        else if (req_ack)
        begin
            req <= 1'b0;
        end
        else if (tx_accept)
        begin
            req <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_accept)
        begin
            tx_data <= wdata[7:0];  // held while req is high
        end
    end

endmodule : uart_reg_decode

// File: rtl/uart_transmitter.sv
`timescale 1ns/1ps

module uart_transmitter
    import uart_pkg::*;
#(
    parameter int CNT_W = CNT_W_DEF
)
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                tr_en,      // transmitter enable
    input  logic [CNT_W-1:0]    comp,       // bit length minus one
    input  logic [7:0]          tx_data,    // byte to send
    input  logic                req,        // request level
    output logic                req_ack,    // one cycle at end of stop bit
    output logic                busy,       // out of idle
    output logic                uart_tx     // serial line
);

    typedef enum logic [2:0] {IDLE, START, TRANSMIT, STOP, WAIT} tx_state_e;

    tx_state_e          state;
    tx_state_e          next_state;
    logic [7:0]         shift_q;    // remaining data bits, lsb first
    logic [3:0]         bit_cnt;    // data bits sent
    logic [CNT_W-1:0]   baud_cnt;
    logic               bit_end;    // last cycle of a bit
    logic               line_q;

    assign bit_end = baud_cnt >= comp;
    assign busy    = state != IDLE;
    assign uart_tx = line_q;

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            state <= IDLE;
        end
        else if (!tr_en)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:     if (req)              next_state = START;
            START:    if (bit_end)          next_state = TRANSMIT;
            TRANSMIT: if (bit_cnt == 4'd8)  next_state = STOP;
            STOP:     if (bit_end)          next_state = WAIT;
            WAIT:     if (req_ack)          next_state = IDLE;
            default:                        next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            bit_cnt  <= '0;
            baud_cnt <= '0;
            line_q   <= 1'b1;
            req_ack  <= 1'b0;
        end
        else
        begin
            req_ack <= 1'b0;
            if (!tr_en)
            begin
                bit_cnt  <= '0;
                baud_cnt <= '0;
                line_q   <= 1'b1;
            end
            else
            begin
                case (state)
                    IDLE:
                    begin
                        line_q   <= 1'b1;
                        bit_cnt  <= '0;
                        baud_cnt <= '0;
                    end
                    START:
                    begin
                        line_q   <= 1'b0;   // start bit
                        baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                    end
                    TRANSMIT:
                    begin
                        if (bit_cnt == 4'd8)
                        begin
                            line_q   <= 1'b1;   // stop bit begins
                            baud_cnt <= '0;
                        end
                        else
                        begin
                            line_q   <= shift_q[0];
                            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                            if (bit_end)
                            begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                    STOP:
                    begin
                        line_q   <= 1'b1;
                        baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                        req_ack  <= bit_end;
                    end
                    default:
                    begin
                        line_q <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && req)
        begin
            shift_q <= tx_data;
        end
        else if (state == TRANSMIT && bit_end && bit_cnt != 4'd8)
        begin
            shift_q <= shift_q >> 1;    // next bit to position 0
        end
    end

endmodule : uart_transmitter

// File: rtl/uart_receiver.sv
`timescale 1ns/1ps

module uart_receiver
    import uart_pkg::*;
#(
    parameter int CNT_W = CNT_W_DEF
)
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                rec_en,     // receiver enable
    input  logic [CNT_W-1:0]    comp,       // bit length minus one
    input  logic                uart_rx,    // serial line, asynchronous
    output logic [7:0]          rx_byte,    // valid with rx_strobe
    output logic                rx_strobe,  // one cycle per frame
    output logic                frame_err   // stop bit low, valid with rx_strobe
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e          state;
    logic [1:0]         sync_q;     // two-stage synchronizer
    logic               rx_s;
    logic               rx_prev;
    logic               start_edge;
    logic [CNT_W-1:0]   baud_cnt;
    logic [CNT_W-1:0]   half_comp;
    logic               bit_end;
    logic               half_end;
    logic [2:0]         bit_cnt;
    logic [7:0]         shift_q;

    assign rx_s       = sync_q[1];
    assign start_edge = rx_prev & ~rx_s;
    assign half_comp  = comp >> 1;
    assign bit_end    = baud_cnt >= comp;
    assign half_end   = baud_cnt >= half_comp;
    assign rx_byte    = shift_q;

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end
        else
        begin
            sync_q  <= {sync_q[0], uart_rx};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= RX_IDLE;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            rx_strobe <= 1'b0;
            frame_err <= 1'b0;
        end
        else
        begin
            rx_strobe <= 1'b0;
            if (!rec_en)
            begin
                state    <= RX_IDLE;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
            else
            begin
                case (state)
                    RX_IDLE:
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        if (start_edge)
                        begin
                            state <= RX_START;
                        end
                    end
                    RX_START:
                    begin
                        baud_cnt <= half_end ? '0 : baud_cnt + 1'b1;
                        if (half_end)
                        begin
                            state <= rx_s ? RX_IDLE : RX_DATA;  // high again means a glitch
                        end
                    end
                    RX_DATA:
                    begin
                        baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                        if (bit_end)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7)
                            begin
                                state <= RX_STOP;
                            end
                        end
                    end
                    RX_STOP:
                    begin
                        baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                        if (bit_end)
                        begin
                            rx_strobe <= 1'b1;  // middle of stop bit
                            frame_err <= ~rx_s;
                            state     <= RX_IDLE;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == RX_DATA && bit_end)
        begin
            shift_q <= {rx_s, shift_q[7:1]};    // lsb arrives first
        end
    end

endmodule : uart_receiver

// File: rtl/uart_result.sv
`timescale 1ns/1ps

module uart_result
    import uart_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    re,         // host read strobe
    input  uart_addr_e              addr,       // word address
    input  uart_ctrl_t              ctrl,
    input  logic [CNT_W_DEF-1:0]    comp,
    input  logic                    req,        // pending transmit request
    input  logic                    tx_busy,    // transmitter out of idle
    input  logic [7:0]              rx_byte,
    input  logic                    rx_strobe,
    input  logic                    frame_err,
    output logic [DATA_W-1:0]       rdata
);

    logic [7:0]     rx_hold;    // last received byte
    logic           rx_valid;
    logic           rx_frame_err;
    logic           stat_rd;
    uart_stat_t     stat;

    assign stat_rd = re && (addr == STAT_A);

    // a fresh byte beats the clearing read in the same cycle
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            rx_hold      <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end
        else if (rx_strobe)
        begin
            rx_hold      <= rx_byte;
            rx_valid     <= 1'b1;
            rx_frame_err <= frame_err;
        end
        else if (stat_rd)
        begin
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end
    end

    always_comb
    begin
        stat              = '0;
        stat.tx_busy      = req | tx_busy;
        stat.rx_valid     = rx_valid;
        stat.rx_frame_err = rx_frame_err;
        case (addr)
            CTRL_A:  rdata = DATA_W'(ctrl);
            COMP_A:  rdata = DATA_W'(comp);
            STAT_A:  rdata = DATA_W'({rx_hold, stat});
            default: rdata = '0;    // transmit data is write only
        endcase
    end

endmodule : uart_result

// File: rtl/uart_top.sv
`timescale 1ns/1ps

module uart_top
    import uart_pkg::*;
#(
    parameter int CNT_W = CNT_W_DEF
)
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                we,
    input  logic                re,
    input  uart_addr_e          addr,
    input  logic [DATA_W-1:0]   wdata,
    output logic [DATA_W-1:0]   rdata,
    input  logic                uart_rx,
    output logic                uart_tx
);

    uart_ctrl_t             ctrl;
    logic [CNT_W-1:0]       comp;
    logic [CNT_W_DEF-1:0]   comp_rd;    // compare value as seen by reads
    logic [7:0]             tx_data;
    logic                   req;
    logic                   req_ack;
    logic                   tx_busy;
    logic [7:0]             rx_byte;
    logic                   rx_strobe;
    logic                   frame_err;

    assign comp_rd = CNT_W_DEF'(comp);

    uart_reg_decode #(.CNT_W(CNT_W)) uart_reg_decode_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .we      (we),
        .addr    (addr),
        .wdata   (wdata),
        .req_ack (req_ack),
        .ctrl    (ctrl),
        .comp    (comp),
        .tx_data (tx_data),
        .req     (req)
    );

    uart_transmitter #(.CNT_W(CNT_W)) uart_transmitter_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .tr_en   (ctrl.tr_en),
        .comp    (comp),
        .tx_data (tx_data),
        .req     (req),
        .req_ack (req_ack),
        .busy    (tx_busy),
        .uart_tx (uart_tx)
    );

    uart_receiver #(.CNT_W(CNT_W)) uart_receiver_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .rec_en    (ctrl.rec_en),
        .comp      (comp),
        .uart_rx   (uart_rx),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe),
        .frame_err (frame_err)
    );

    uart_result uart_result_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .re        (re),
        .addr      (addr),
        .ctrl      (ctrl),
        .comp      (comp_rd),
        .req       (req),
        .tx_busy   (tx_busy),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe),
        .frame_err (frame_err),
        .rdata     (rdata)
    );

endmodule : uart_top

// File: sim/uart_asserts.sv
`timescale 1ns/1ps

module uart_asserts
(
    input logic clk,
    input logic resetn,
    input logic tr_en,
    input logic req_ack,
    input logic busy,
    input logic uart_tx
);

    property ack_single;
        @(posedge clk) disable iff (!resetn)
        req_ack |=> !req_ack;   // end of frame is one pulse
    endproperty

    property line_high_when_off;
        @(posedge clk) disable iff (!resetn)
        !tr_en |=> uart_tx;     // line back high the cycle after
    endproperty

    property idle_after_reset;
        @(posedge clk)
        $rose(resetn) |-> !busy;
    endproperty

    ack_single_a: assert property (ack_single)
        else $error("req_ack stayed high for more than one cycle");

    line_high_when_off_a: assert property (line_high_when_off)
        else $error("uart_tx was not high the cycle after the transmitter was disabled");

    idle_after_reset_a: assert property (idle_after_reset)
        else $error("transmitter was busy in the cycle after reset");

endmodule : uart_asserts

bind uart_transmitter uart_asserts uart_asserts_i
(
    .clk     (clk),
    .resetn  (resetn),
    .tr_en   (tr_en),
    .req_ack (req_ack),
    .busy    (busy),
    .uart_tx (uart_tx)
);

// File: sim/uart_tb.sv
`timescale 1ns/1ps

module uart_tb
    import uart_pkg::*;
();

    localparam int N_RAND      = 8;
    localparam int NUM_FRAMES  = N_RAND + 3;    // random, framing error, abort, resend
    localparam int CYCLE_LIMIT = NUM_FRAMES * 10 * 16 + 2000;

    logic               clk = 1'b0;
    logic               resetn;
    logic               we;
    logic               re;
    uart_addr_e         addr;
    logic [DATA_W-1:0]  wdata;
    logic [DATA_W-1:0]  rdata;
    logic               uart_tx;
    logic               uart_rx;
    logic               loopback;   // uart_rx follows uart_tx
    logic               rx_drive;   // line driven by the testbench
    integer             seed;
    int                 bit_len;    // comp + 1 cycles
    int                 errors    = 0;
    int                 checks    = 0;
    int                 cycle_cnt = 0;
    logic [DATA_W-1:0]  d;
    logic [DATA_W-1:0]  v;
    int                 i;

    assign uart_rx = loopback ? uart_tx : rx_drive;

    uart_top #(.CNT_W(CNT_W_DEF)) uart_top_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .we      (we),
        .re      (re),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .uart_rx (uart_rx),
        .uart_tx (uart_tx)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, the test did not complete", cycle_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic write_reg(input uart_addr_e a, input logic [DATA_W-1:0] val);
        @(negedge clk);
        we    = 1'b1;
        addr  = a;
        wdata = val;
        @(negedge clk);
        we    = 1'b0;
    endtask

    task automatic read_reg(input uart_addr_e a, input logic clr,
                            output logic [DATA_W-1:0] val);
        @(negedge clk);
        addr = a;
        re   = clr;
        #25;
        val  = rdata;   // settled, well before the next rising edge
        @(negedge clk);
        re   = 1'b0;
    endtask

    task automatic set_comp();
        int c;
        c = 3 + ($unsigned($random(seed)) % 13);
        write_reg(COMP_A, DATA_W'(c));
        bit_len = c + 1;
    endtask

    task automatic wait_start(output bit found);
        int waited;
        waited = 0;
        while (uart_tx !== 1'b0 && waited < 4 * bit_len)
        begin
            @(negedge clk);
            waited++;
        end
        found = (uart_tx === 1'b0);
        checks++;
        assert (found)
        else
        begin
            errors++;
            $display("no start bit appeared on uart_tx after the transmit write");
        end
    endtask

    // line model samples each bit at its center, counted from the falling edge
    task automatic send_frame(input logic [7:0] b);
        logic [9:0]         exp_bits;
        logic [DATA_W-1:0]  st;
        logic               line_high;
        bit                 found;
        int                 half;
        int                 c;
        int                 k;
        exp_bits = {1'b1, b, 1'b0};
        half     = bit_len / 2;
        write_reg(TXD_A, DATA_W'(b));
        wait_start(found);
        if (!found)
        begin
            return;
        end
        for (c = 1; c <= 9 * bit_len + half; c++)
        begin
            @(negedge clk);
            if (c >= half && (c - half) % bit_len == 0)
            begin
                k = (c - half) / bit_len;
                check_value($sformatf("uart_tx bit %0d", k), exp_bits[k], uart_tx);
            end
            if (c == 2)
            begin
                we    = 1'b1;   // second byte while busy, must be dropped
                addr  = TXD_A;
                wdata = $random(seed);
            end
            else if (c == 3)
            begin
                we   = 1'b0;
                addr = STAT_A;
                #25;
                check_value("tx_busy", 1, rdata[0]);
            end
        end
        k = 0;
        do
        begin
            @(negedge clk);
            addr = STAT_A;
            #25;
            k++;
        end
        while (rdata[0] !== 1'b0 && k < bit_len + 8);
        check_value("tx_busy", 0, rdata[0]);
        line_high = 1'b1;
        repeat (2 * bit_len)
        begin
            @(negedge clk);
            line_high &= uart_tx;   // no second frame
        end
        check_value("uart_tx idle", 1, line_high);
        read_reg(STAT_A, 1'b1, st);
        check_value("rx_valid", 1, st[1]);
        check_value("rx_frame_err", 0, st[2]);
        check_value("rx byte", b, st[15:8]);
        read_reg(STAT_A, 1'b1, st);
        check_value("rx_valid", 0, st[1]);
    endtask

    task automatic bad_frame(input logic [7:0] b);
        logic [9:0]         bits;
        logic [DATA_W-1:0]  st;
        int                 k;
        bits     = {1'b0, b, 1'b0};     // stop bit held low
        loopback = 1'b0;
        for (k = 0; k < 10; k++)
        begin
            @(negedge clk);
            rx_drive = bits[k];
            repeat (bit_len - 1) @(negedge clk);
        end
        @(negedge clk);
        rx_drive = 1'b1;
        repeat (2 * bit_len) @(negedge clk);
        read_reg(STAT_A, 1'b1, st);
        check_value("rx_frame_err", 1, st[2]);
        check_value("rx_valid", 1, st[1]);
        check_value("rx byte", b, st[15:8]);
        loopback = 1'b1;
    endtask

    task automatic abort_frame(input logic [7:0] b, input logic [7:0] b_next);
        logic [DATA_W-1:0]  st;
        logic               line_high;
        bit                 found;
        write_reg(TXD_A, DATA_W'(b));
        wait_start(found);
        repeat (3 * bit_len) @(negedge clk);
        write_reg(CTRL_A, '0);      // both directions off mid frame
        repeat (2) @(negedge clk);  // line returns high within two cycles
        line_high = 1'b1;
        repeat (2 * bit_len)
        begin
            line_high &= uart_tx;
            @(negedge clk);
        end
        check_value("uart_tx after disable", 1, line_high);
        read_reg(STAT_A, 1'b0, st);
        check_value("tx_busy", 0, st[0]);
        write_reg(CTRL_A, 32'h3);
        send_frame(b_next);
    endtask

    initial
    begin
        seed     = 32'hf9e0;
        resetn   = 1'b0;
        we       = 1'b0;
        re       = 1'b0;
        addr     = CTRL_A;
        wdata    = '0;
        loopback = 1'b1;
        rx_drive = 1'b1;
        bit_len  = 4;
        repeat (4) @(negedge clk);
        resetn = 1'b1;

        read_reg(STAT_A, 1'b0, d);
        check_value("rdata STAT_A after reset", 0, d);
        for (i = 0; i < 4; i++)
        begin
            v = $random(seed);
            write_reg(CTRL_A, v);
            read_reg(CTRL_A, 1'b0, d);
            check_value("rdata CTRL_A", v & 32'h3, d);
            v = $random(seed);
            write_reg(COMP_A, v);
            read_reg(COMP_A, 1'b0, d);
            check_value("rdata COMP_A", v & ((32'h1 << CNT_W_DEF) - 1), d);
        end

        write_reg(CTRL_A, 32'h3);   // tx and rx on
        for (i = 0; i < N_RAND; i++)
        begin
            set_comp();
            send_frame(8'($random(seed)));
        end
        set_comp();
        bad_frame(8'($random(seed)));
        set_comp();
        abort_frame(8'($random(seed)), 8'($random(seed)));

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : uart_tb

// File: sources.f
rtl/uart_pkg.sv
rtl/uart_reg_decode.sv
rtl/uart_transmitter.sv
rtl/uart_receiver.sv
rtl/uart_result.sv
rtl/uart_top.sv
sim/uart_asserts.sv
sim/uart_tb.sv

// File: Bender.yml
package:
  name: uart

sources:
  - rtl/uart_pkg.sv
  - rtl/uart_reg_decode.sv
  - rtl/uart_transmitter.sv
  - rtl/uart_receiver.sv
  - rtl/uart_result.sv
  - rtl/uart_top.sv
  - target: simulation
    files:
      - sim/uart_asserts.sv
      - sim/uart_tb.sv
